/* Bender.yml */
package:
  name: cfu_tpu

sources:
  - include_dirs:
      - src
    files:
      - src/tpu_pkg.sv
      - src/global_buffer.sv
      - src/systolic_pe.sv
      - src/operand_skew.sv
      - src/systolic_array.sv
      - src/tpu_ctrl.sv
      - src/cfu_tpu.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_cfu_tpu.sv

/* project.f */
+incdir+src
src/tpu_pkg.sv
src/global_buffer.sv
src/systolic_pe.sv
src/operand_skew.sv
src/systolic_array.sv
src/tpu_ctrl.sv
src/cfu_tpu.sv
test/tb_cfu_tpu.sv

/* src/cfu_tpu.sv */
// Same-cycle response; buffer writes during a run steal the read port and corrupt that run
`timescale 1ns/1ns
`default_nettype none

`include "tpu_cfg.svh"

module cfu_tpu (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           cmd_valid,
    output logic                cmd_ready,
    input  wire logic [9:0]     cmd_function_id,
    input  wire tpu_pkg::word_t cmd_input_0,
    input  wire tpu_pkg::word_t cmd_input_1,
    output logic                rsp_valid,
    input  wire logic           rsp_ready,
    output tpu_pkg::word_t      rsp_output
);

    tpu_pkg::tpu_op_t op_code;

    logic                        accept;
    logic                        wr_a;
    logic                        wr_b;
    logic                        set_k;
    logic                        start_pulse;
    logic [3:0]                  c_index;
    logic [`TPU_ADDR_BITS-1:0]   rd_addr;
    logic [`TPU_ADDR_BITS-1:0]   addr_a;
    logic [`TPU_ADDR_BITS-1:0]   addr_b;
    logic                        feed;
    logic                        run;
    logic                        capture;
    logic                        busy;
    tpu_pkg::word_t              data_a;
    tpu_pkg::word_t              data_b;
    tpu_pkg::result_t            result;

    tpu_pkg::operand_t [`TPU_SA_SIZE-1:0] a_lane;
    tpu_pkg::operand_t [`TPU_SA_SIZE-1:0] b_lane;

    // ==================================================
    // Handshake and decode
    // ==================================================
    assign cmd_ready = rsp_ready;
    assign rsp_valid = cmd_valid;
    assign accept    = cmd_valid && rsp_ready;
    assign op_code   = tpu_pkg::tpu_op_t'(cmd_function_id[9:3]);

    assign wr_a  = accept && (op_code == tpu_pkg::op_write_a);
    assign wr_b  = accept && (op_code == tpu_pkg::op_write_b);
    assign set_k = accept && (op_code == tpu_pkg::op_set_k);

    // Start reaches the controller one cycle after acceptance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= accept && (op_code == tpu_pkg::op_start);
        end
    end

    // Command address overrides the controller on a write
    assign addr_a = wr_a ? cmd_input_0[`TPU_ADDR_BITS-1:0] : rd_addr;
    assign addr_b = wr_b ? cmd_input_0[`TPU_ADDR_BITS-1:0] : rd_addr;

    // ==================================================
    // Datapath
    // ==================================================
    global_buffer gbuf_a (
        .clk(clk), .wr_en(wr_a), .addr(addr_a), .wr_data(cmd_input_1), .rd_data(data_a)
    );

    global_buffer gbuf_b (
        .clk(clk), .wr_en(wr_b), .addr(addr_b), .wr_data(cmd_input_1), .rd_data(data_b)
    );

    tpu_ctrl ctrl_i (
        .clk(clk), .rst_n(rst_n), .set_k(set_k), .k_value(cmd_input_0[`TPU_K_BITS-1:0]),
        .start(start_pulse), .rd_addr(rd_addr), .feed(feed), .run(run),
        .capture(capture), .busy(busy)
    );

    operand_skew skew_a (
        .clk(clk), .rst_n(rst_n), .word(data_a), .feed(feed), .run(run), .lane(a_lane)
    );

    operand_skew skew_b (
        .clk(clk), .rst_n(rst_n), .word(data_b), .feed(feed), .run(run), .lane(b_lane)
    );

    systolic_array array_i (
        .clk(clk), .rst_n(rst_n), .a_lane(a_lane), .b_lane(b_lane),
        .run(run), .capture(capture), .result(result)
    );

    // ==================================================
    // Response
    // ==================================================
    // Row in bits 3:2, column in bits 1:0
    assign c_index = 4'(op_code - tpu_pkg::op_read_c_first);

    always_comb begin
        rsp_output = '0;
        if (accept) begin
            if (op_code == tpu_pkg::op_read_busy) begin
                rsp_output = {{(`TPU_WORD_BITS-1){1'b0}}, busy};
            end else if (op_code >= tpu_pkg::op_read_c_first &&
                         op_code <= tpu_pkg::op_read_c_last) begin
                rsp_output = result[c_index[3:2]][c_index[1:0]];
            end
        end
    end

endmodule

`default_nettype wire

/* src/global_buffer.sv */
// No reset on the contents; a write cycle skips the read and addresses past depth are unchecked
`timescale 1ns/1ns
`default_nettype none

`include "tpu_cfg.svh"

module global_buffer #(
    parameter int depth = `TPU_BUF_DEPTH
) (
    input  wire logic                      clk,
    input  wire logic                      wr_en,
    input  wire logic [`TPU_ADDR_BITS-1:0] addr,
    input  wire tpu_pkg::word_t            wr_data,
    output tpu_pkg::word_t                 rd_data
);

    tpu_pkg::word_t mem [depth];

    // One access per cycle, write wins over read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end else begin
            rd_data <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* src/operand_skew.sv */
// Lane i sees its byte i+1 cycles after the word; zeros go in whenever feed is low
`timescale 1ns/1ns
`default_nettype none

`include "tpu_cfg.svh"

module operand_skew (
    input  wire logic                                      clk,
    input  wire logic                                      rst_n,
    input  wire tpu_pkg::word_t                            word,
    input  wire logic                                      feed,
    input  wire logic                                      run,
    output tpu_pkg::operand_t [`TPU_SA_SIZE-1:0]           lane
);

    // ==================================================
    // One delay line per lane, longer further down
    // ==================================================
    for (genvar i = 0; i < `TPU_SA_SIZE; i++) begin : g_lane
        tpu_pkg::operand_t       head;
        tpu_pkg::operand_t [i:0] taps;

        // Most significant byte feeds lane 0
        assign head = feed ? word[`TPU_WORD_BITS-1-i*`TPU_DATA_BITS -: `TPU_DATA_BITS] : '0;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                taps <= '0;
            end else if (!run) begin
                taps <= '0;
            end else begin
                taps[0] <= head;
                for (int s = 1; s <= i; s++) begin
                    taps[s] <= taps[s-1];
                end
            end
        end

        assign lane[i] = taps[i];
    end

endmodule

`default_nettype wire

/* src/systolic_array.sv */
// Fixed 4x4 grid; result is cleared for the whole compute phase and valid only afterwards
`timescale 1ns/1ns
`default_nettype none

`include "tpu_cfg.svh"

module systolic_array (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire tpu_pkg::operand_t [`TPU_SA_SIZE-1:0] a_lane,
    input  wire tpu_pkg::operand_t [`TPU_SA_SIZE-1:0] b_lane,
    input  wire logic                                run,
    input  wire logic                                capture,
    output tpu_pkg::result_t                         result
);

    // A moves along rows, B moves down columns
    wire tpu_pkg::operand_t a_link [`TPU_SA_SIZE][`TPU_SA_SIZE+1];
    wire tpu_pkg::operand_t b_link [`TPU_SA_SIZE+1][`TPU_SA_SIZE];
    wire tpu_pkg::result_t  psum;

    tpu_pkg::result_t bank;

    // ==================================================
    // Element grid
    // ==================================================
    for (genvar r = 0; r < `TPU_SA_SIZE; r++) begin : g_row
        assign a_link[r][0] = a_lane[r];
        assign b_link[0][r] = b_lane[r];

        for (genvar c = 0; c < `TPU_SA_SIZE; c++) begin : g_col
            systolic_pe pe_i (
                .clk   (clk),
                .rst_n (rst_n),
                .run   (run),
                .a_in  (a_link[r][c]),
                .b_in  (b_link[r][c]),
                .a_out (a_link[r][c+1]),
                .b_out (b_link[r+1][c]),
                .psum  (psum[r][c])
            );
        end
    end

    // ==================================================
    // Result bank and output register
    // ==================================================
    // Tracks the sums until compute ends, then holds
    always_ff @(posedge clk) begin
        if (run) begin
            bank <= psum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (run) begin
            result <= '0;
        end else if (capture) begin
            result <= bank;
        end
    end

endmodule

`default_nettype wire

/* src/systolic_pe.sv */
// Operands are signed bytes; only the A side gets the input offset, and sums wrap at 32 bits
`timescale 1ns/1ns
`default_nettype none

`include "tpu_cfg.svh"

module systolic_pe (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              run,
    input  wire tpu_pkg::operand_t a_in,
    input  wire tpu_pkg::operand_t b_in,
    output tpu_pkg::operand_t      a_out,
    output tpu_pkg::operand_t      b_out,
    output tpu_pkg::acc_t          psum
);

    tpu_pkg::acc_t a_shifted;

    // A operand moved into the unsigned range 0..255
    assign a_shifted = tpu_pkg::acc_t'(a_out) + tpu_pkg::acc_t'(`TPU_INPUT_OFFSET);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_out <= '0;
            b_out <= '0;
            psum  <= '0;
        end else if (!run) begin
            // Flush between products
            a_out <= '0;
            b_out <= '0;
            psum  <= '0;
        end else begin
            a_out <= a_in;
            b_out <= b_in;
            psum  <= psum + a_shifted * tpu_pkg::acc_t'(b_out);
        end
    end

endmodule

`default_nettype wire

/* src/tpu_cfg.svh */
// Sizes are tied together: a buffer word must hold exactly TPU_SA_SIZE operands of TPU_DATA_BITS
`ifndef TPU_CFG_SVH
`define TPU_CFG_SVH

// ==================================================
// Data widths
// ==================================================
`define TPU_WORD_BITS    32
`define TPU_DATA_BITS    8
`define TPU_ACC_BITS     32
// Array side, also the number of bytes per word
`define TPU_SA_SIZE      4

// Buffer geometry and command fields
`define TPU_BUF_DEPTH    576
`define TPU_ADDR_BITS    10
`define TPU_K_BITS       10
`define TPU_OP_BITS      7

// Zero point added to each A operand
`define TPU_INPUT_OFFSET 128
// Extra compute cycles so the last wavefront leaves the array
`define TPU_DRAIN_CYCLES 8

`endif

/* src/tpu_ctrl.sv */
// K is latched only by set_k; start is ignored unless idle, and addresses wrap at TPU_ADDR_BITS
`timescale 1ns/1ns
`default_nettype none

`include "tpu_cfg.svh"

module tpu_ctrl (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      set_k,
    input  wire logic [`TPU_K_BITS-1:0]    k_value,
    input  wire logic                      start,
    output logic [`TPU_ADDR_BITS-1:0]      rd_addr,
    output logic                           feed,
    output logic                           run,
    output logic                           capture,
    output logic                           busy
);

    tpu_pkg::tpu_state_t state;
    tpu_pkg::tpu_state_t state_next;

    logic [`TPU_K_BITS-1:0] k_reg;
    // One bit wider so K plus drain cannot wrap
    logic [`TPU_K_BITS:0]   step_cnt;
    logic [`TPU_K_BITS:0]   last_step;
    logic [1:0]             wb_cnt;

    assign last_step = k_reg + (`TPU_K_BITS+1)'(`TPU_DRAIN_CYCLES);

    assign run     = (state == tpu_pkg::st_compute);
    assign capture = (state == tpu_pkg::st_write_back);
    assign feed    = run && (step_cnt < {1'b0, k_reg});

    // ==================================================
    // Sequencer
    // ==================================================
    always_comb begin
        case (state)
            tpu_pkg::st_idle:       state_next = start ? tpu_pkg::st_compute : tpu_pkg::st_idle;
            tpu_pkg::st_compute:    state_next = (step_cnt == last_step) ?
                                                 tpu_pkg::st_write_back : tpu_pkg::st_compute;
            tpu_pkg::st_write_back: state_next = (wb_cnt == 2'd3) ?
                                                 tpu_pkg::st_idle : tpu_pkg::st_write_back;
            default:                state_next = tpu_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= tpu_pkg::st_idle;
            k_reg    <= '0;
            step_cnt <= '0;
            wb_cnt   <= '0;
            busy     <= 1'b0;
        end else begin
            state    <= state_next;
            step_cnt <= run ? step_cnt + 1'b1 : '0;
            wb_cnt   <= capture ? wb_cnt + 1'b1 : '0;
            if (set_k) begin
                k_reg <= k_value;
            end
            // Drops one cycle after the return to idle
            if (start) begin
                busy <= 1'b1;
            end else if (state == tpu_pkg::st_idle) begin
                busy <= 1'b0;
            end
        end
    end

    // Shared A/B read address, one word ahead of the data in use
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else begin
            case (state)
                tpu_pkg::st_idle:    rd_addr <= start ? rd_addr + 1'b1 : '0;
                tpu_pkg::st_compute: begin
                    if (step_cnt <= {1'b0, k_reg}) begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                end
                // Back at word 0 before the controller reaches idle
                default:             rd_addr <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/tpu_pkg.sv */
// Types follow the widths in tpu_cfg.svh; opcodes 0 and 22 to 127 are left unassigned
`default_nettype none

`include "tpu_cfg.svh"

package tpu_pkg;

    // ==================================================
    // Command opcodes, taken from function id bits 9:3
    // ==================================================
    typedef enum logic [`TPU_OP_BITS-1:0] {
        op_reserved     = `TPU_OP_BITS'(0),
        op_write_a      = `TPU_OP_BITS'(1),
        op_write_b      = `TPU_OP_BITS'(2),
        op_start        = `TPU_OP_BITS'(3),
        op_read_busy    = `TPU_OP_BITS'(4),
        // C[0][0] .. C[3][3] sit on 5 .. 20, row major
        op_read_c_first = `TPU_OP_BITS'(5),
        op_read_c_last  = `TPU_OP_BITS'(20),
        op_set_k        = `TPU_OP_BITS'(21)
    } tpu_op_t;

    // Sequencer states
    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_write_back
    } tpu_state_t;

    // ==================================================
    // Data types
    // ==================================================
    typedef logic [`TPU_WORD_BITS-1:0] word_t;
    typedef logic signed [`TPU_DATA_BITS-1:0] operand_t;
    typedef logic signed [`TPU_ACC_BITS-1:0] acc_t;

    // Indexed as result[row][col]
    typedef acc_t [`TPU_SA_SIZE-1:0][`TPU_SA_SIZE-1:0] result_t;

endpackage

`default_nettype wire

/* test/tb_cfu_tpu.sv */
// Commands go out one at a time with an idle cycle between them; buffers are never written mid-run
`timescale 1ns/1ns
`default_nettype none

`include "tpu_cfg.svh"

module tb_cfu_tpu;

    localparam int clk_period   = 100;
    localparam int drive_delay  = 10;
    localparam int sample_delay = 40;
    localparam int max_k        = 16;
    localparam int busy_polls   = 200;

    logic           clk;
    logic           rst_n;
    logic           cmd_valid;
    logic           cmd_ready;
    logic [9:0]     cmd_function_id;
    tpu_pkg::word_t cmd_input_0;
    tpu_pkg::word_t cmd_input_1;
    logic           rsp_valid;
    logic           rsp_ready;
    tpu_pkg::word_t rsp_output;

    // Testbench copy of what the buffers hold
    tpu_pkg::word_t a_words [max_k];
    tpu_pkg::word_t b_words [max_k];

    integer seed;

    cfu_tpu cfu_tpu_i (
        .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .cmd_function_id(cmd_function_id), .cmd_input_0(cmd_input_0),
        .cmd_input_1(cmd_input_1), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
        .rsp_output(rsp_output)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // One command; response sampled mid-cycle, taken at the following edge
    task automatic send_cmd(input logic [`TPU_OP_BITS-1:0] op, input tpu_pkg::word_t in_0,
                            input tpu_pkg::word_t in_1, input logic ready,
                            output tpu_pkg::word_t rsp);
        @(posedge clk);
        #drive_delay;
        cmd_valid       = 1'b1;
        cmd_function_id = {op, 3'b000};
        cmd_input_0     = in_0;
        cmd_input_1     = in_1;
        rsp_ready       = ready;
        #sample_delay;
        check_value(32'(rsp_valid), 32'd1, "rsp_valid");
        check_value(32'(cmd_ready), 32'(ready), "cmd_ready");
        rsp = rsp_output;
        @(posedge clk);
        #drive_delay;
        cmd_valid = 1'b0;
        rsp_ready = 1'b1;
        // Idle cycle, nothing offered
        #sample_delay;
        check_value(32'(rsp_valid), 32'd0, "rsp_valid with no command");
        check_value(rsp_output, 32'd0, "rsp_output with no command");
    endtask

    task automatic write_word(input bit to_b, input int addr, input tpu_pkg::word_t data);
        tpu_pkg::word_t rsp;
        if (to_b) begin
            send_cmd(tpu_pkg::op_write_b, addr, data, 1'b1, rsp);
            b_words[addr] = data;
        end else begin
            send_cmd(tpu_pkg::op_write_a, addr, data, 1'b1, rsp);
            a_words[addr] = data;
        end
        check_value(rsp, 32'd0, "write response");
    endtask

    task automatic read_c(input int row, input int col, output tpu_pkg::word_t value);
        logic [`TPU_OP_BITS-1:0] op;
        op = `TPU_OP_BITS'(int'(tpu_pkg::op_read_c_first) + row * 4 + col);
        send_cmd(op, '0, '0, 1'b1, value);
    endtask

    // Sum of (A byte + 128) * B byte over k steps, byte 0 is the top byte
    function automatic logic [31:0] expected_c(input int row, input int col, input int k);
        int  sum;
        byte a_byte;
        byte b_byte;
        sum = 0;
        for (int s = 0; s < k; s++) begin
            a_byte = a_words[s][31 - 8 * row -: 8];
            b_byte = b_words[s][31 - 8 * col -: 8];
            sum += (int'(a_byte) + 128) * int'(b_byte);
        end
        return sum;
    endfunction

    // Busy is sure to be set two cycles after start
    task automatic wait_idle();
        tpu_pkg::word_t rsp;
        int             polls;
        polls = 0;
        repeat (2) @(posedge clk);
        send_cmd(tpu_pkg::op_read_busy, '0, '0, 1'b1, rsp);
        check_value(rsp, 32'd1, "busy after start");
        while (rsp !== 32'd0) begin
            polls++;
            if (polls > busy_polls) begin
                $display("Timeout: busy flag still set after %0d polls", busy_polls);
                $display("TESTS FAILED");
                $fatal(1, "Busy never cleared");
            end
            send_cmd(tpu_pkg::op_read_busy, '0, '0, 1'b1, rsp);
        end
    endtask

    task automatic check_results(input int k, input string label);
        tpu_pkg::word_t value;
        for (int row = 0; row < 4; row++) begin
            for (int col = 0; col < 4; col++) begin
                read_c(row, col, value);
                check_value(value, expected_c(row, col, k),
                            $sformatf("%s C[%0d][%0d]", label, row, col));
            end
        end
    endtask

    task automatic run_product(input int k, input string label);
        tpu_pkg::word_t rsp;
        send_cmd(tpu_pkg::op_set_k, k, '0, 1'b1, rsp);
        check_value(rsp, 32'd0, "set_k response");
        send_cmd(tpu_pkg::op_start, '0, '0, 1'b1, rsp);
        check_value(rsp, 32'd0, "start response");
        wait_idle();
        check_results(k, label);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_reset_state();
        tpu_pkg::word_t rsp;
        send_cmd(tpu_pkg::op_read_busy, '0, '0, 1'b1, rsp);
        check_value(rsp, 32'd0, "busy after reset");
        for (int row = 0; row < 4; row++) begin
            for (int col = 0; col < 4; col++) begin
                read_c(row, col, rsp);
                check_value(rsp, 32'd0, $sformatf("reset C[%0d][%0d]", row, col));
            end
        end
    endtask

    task automatic test_single_step();
        // Bytes -128, 127, 0, 1 against 127, -128, -1, 2
        write_word(1'b0, 0, 32'h807f_0001);
        write_word(1'b1, 0, 32'h7f80_ff02);
        run_product(1, "k1");
    endtask

    task automatic test_random_k16();
        for (int i = 0; i < max_k; i++) begin
            write_word(1'b0, i, $random(seed));
            write_word(1'b1, i, $random(seed));
        end
        run_product(16, "k16");
    endtask

    task automatic test_back_pressure();
        tpu_pkg::word_t rsp;
        send_cmd(tpu_pkg::op_write_a, 0, ~a_words[0], 1'b0, rsp);
        check_value(rsp, 32'd0, "stalled write response");
        run_product(16, "after stall");
    endtask

    task automatic test_reserved_ops();
        tpu_pkg::word_t         rsp;
        logic [`TPU_OP_BITS-1:0] ops [3];
        ops = '{7'd0, 7'd22, 7'd127};
        foreach (ops[i]) begin
            send_cmd(ops[i], 3, 32'hdead_beef, 1'b1, rsp);
            check_value(rsp, 32'd0, $sformatf("opcode %0d response", ops[i]));
        end
        send_cmd(tpu_pkg::op_read_busy, '0, '0, 1'b1, rsp);
        check_value(rsp, 32'd0, "busy after reserved opcodes");
        run_product(7, "k7");
    endtask

    initial begin
        seed            = 32'h57fa;
        rst_n           = 1'b0;
        cmd_valid       = 1'b0;
        cmd_function_id = '0;
        cmd_input_0     = '0;
        cmd_input_1     = '0;
        rsp_ready       = 1'b1;
        repeat (16) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;

        test_reset_state();
        test_single_step();
        test_random_k16();
        test_back_pressure();
        test_reserved_ops();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
